/* pixel_mapper_defs.svh */
// sizes, fixed colors and register map offsets of the tank game pixel mapper
`ifndef PIXEL_MAPPER_DEFS_SVH
`define PIXEL_MAPPER_DEFS_SVH

// register bank depths
`define PM_NUM_PALETTE      8
`define PM_NUM_BULLETS      8
`define PM_NUM_WALLS        8

// geometry in pixels
`define PM_WALL_SIZE        32
`define PM_BULLET_RADIUS    4

`define PM_BULLET_RGB       24'hff5500  // orange

// byte offsets on the APB side
`define PM_ADDR_PALETTE     8'h00
`define PM_ADDR_BULLET      8'h20
`define PM_ADDR_WALL        8'h40
`define PM_ADDR_BG          8'h60
`define PM_ADDR_WALLCOL     8'h64

`endif

/* pixel_mapper_pkg.sv */
// shared vector types and layer select encoding for the pixel mapper
package pixel_mapper_pkg;

    typedef logic [9:0]  coord_t;     // screen x or y
    typedef logic [11:0] rgb444_t;    // palette half word
    typedef logic [23:0] rgb888_t;
    typedef logic [31:0] reg_word_t;
    typedef logic [7:0]  apb_addr_t;
    typedef logic [15:0] char_t;      // text cell code
    typedef logic [7:0]  font_row_t;

    // winning layer for one pixel, highest priority first
    typedef enum logic [2:0] {
        layer_blank,
        layer_text,
        layer_bullet,
        layer_wall,
        layer_bg
    } layer_t;

endpackage

/* pixel_mapper_if.sv */
// register state and stage-one layer result bundles of the pixel mapper
`timescale 1ns/1ps
`include "pixel_mapper_defs.svh"

interface regs_if;
    pixel_mapper_pkg::reg_word_t palette [`PM_NUM_PALETTE];
    pixel_mapper_pkg::reg_word_t bullets [`PM_NUM_BULLETS];  // valid, x, y
    pixel_mapper_pkg::reg_word_t walls   [`PM_NUM_WALLS];
    pixel_mapper_pkg::rgb888_t   bg_color;
    pixel_mapper_pkg::rgb888_t   wall_color;

    modport owner (
        output palette,
        output bullets,
        output walls,
        output bg_color,
        output wall_color
    );

    modport user (
        input palette,
        input bullets,
        input walls,
        input bg_color,
        input wall_color
    );
endinterface

interface layer_if;
    logic                      text_on;
    pixel_mapper_pkg::rgb888_t text_color;
    logic                      bullet_on;
    logic                      wall_on;

    // one producer per hit block
    modport text_src   (output text_on, output text_color);
    modport bullet_src (output bullet_on);
    modport wall_src   (output wall_on);

    modport sink (
        input text_on,
        input text_color,
        input bullet_on,
        input wall_on
    );
endinterface

/* apb_regfile.sv */
// APB slave with palette, bullet, wall and color registers and error response
`timescale 1ns/1ps
`include "pixel_mapper_defs.svh"

module apb_regfile (
    input  logic                        pixel_clk,
    input  logic                        rst_n,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  pixel_mapper_pkg::apb_addr_t paddr,
    input  pixel_mapper_pkg::reg_word_t pwdata,
    output pixel_mapper_pkg::reg_word_t prdata,
    output logic                        pready,
    output logic                        pslverr,
    regs_if.owner                       regs
);
    localparam pixel_mapper_pkg::apb_addr_t bank_mask = 8'he0;  // 8-word banks
    localparam pixel_mapper_pkg::apb_addr_t word_mask = 8'hfc;
    localparam int slot_w = $clog2(`PM_NUM_BULLETS);

    logic [slot_w-1:0] slot;
    logic hit_pal;
    logic hit_bul;
    logic hit_wall;
    logic hit_bg;
    logic hit_wcol;
    logic mapped;
    logic wr_en;
    pixel_mapper_pkg::reg_word_t rdata;

    assign slot     = paddr[slot_w+1:2];
    assign hit_pal  = (paddr & bank_mask) == `PM_ADDR_PALETTE;
    assign hit_bul  = (paddr & bank_mask) == `PM_ADDR_BULLET;
    assign hit_wall = (paddr & bank_mask) == `PM_ADDR_WALL;
    assign hit_bg   = (paddr & word_mask) == `PM_ADDR_BG;
    assign hit_wcol = (paddr & word_mask) == `PM_ADDR_WALLCOL;
    assign mapped   = hit_pal | hit_bul | hit_wall | hit_bg | hit_wcol;
    assign wr_en    = psel & penable & pwrite & mapped;
    assign pready   = 1'b1;  // never waits

    always_ff @(posedge pixel_clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `PM_NUM_PALETTE; i++) regs.palette[i] <= '0;
            for (int i = 0; i < `PM_NUM_BULLETS; i++) regs.bullets[i] <= '0;
            for (int i = 0; i < `PM_NUM_WALLS; i++) regs.walls[i] <= '0;
            regs.bg_color   <= '0;
            regs.wall_color <= '0;
        end else if (wr_en) begin
            if (hit_pal) regs.palette[slot] <= pwdata;
            if (hit_bul) regs.bullets[slot] <= pwdata;
            if (hit_wall) regs.walls[slot] <= pwdata;
            if (hit_bg) regs.bg_color <= pwdata[23:0];
            if (hit_wcol) regs.wall_color <= pwdata[23:0];
        end
    end

    always_comb begin
        if (hit_pal) rdata = regs.palette[slot];
        else if (hit_bul) rdata = regs.bullets[slot];
        else if (hit_wall) rdata = regs.walls[slot];
        else if (hit_bg) rdata = {8'h00, regs.bg_color};
        else if (hit_wcol) rdata = {8'h00, regs.wall_color};
        else rdata = '0;  // unmapped reads as zero
    end

    // response loaded in setup so it is valid through the access cycle
    always_ff @(posedge pixel_clk) begin
        if (!rst_n) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end else if (psel && !penable) begin
            prdata  <= pwrite ? '0 : rdata;
            pslverr <= !mapped;
        end else begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end
    end

    a_access_after_setup: assert property (
        @(posedge pixel_clk) disable iff (!rst_n)
        penable |-> psel && $past(psel && !penable)
    );

endmodule

/* bullet_hit.sv */
// circle hit test of the current pixel against every valid bullet
`timescale 1ns/1ps
`include "pixel_mapper_defs.svh"

module bullet_hit (
    input  logic                     pixel_clk,
    input  logic                     rst_n,
    input  pixel_mapper_pkg::coord_t draw_x,
    input  pixel_mapper_pkg::coord_t draw_y,
    regs_if.user                     regs,
    layer_if.bullet_src              layer
);
    localparam logic [22:0] radius_sq = 23'(`PM_BULLET_RADIUS * `PM_BULLET_RADIUS);

    logic signed [10:0] dx    [`PM_NUM_BULLETS];
    logic signed [10:0] dy    [`PM_NUM_BULLETS];
    logic signed [21:0] sq_x  [`PM_NUM_BULLETS];
    logic signed [21:0] sq_y  [`PM_NUM_BULLETS];
    logic [22:0]        dist2 [`PM_NUM_BULLETS];
    logic [`PM_NUM_BULLETS-1:0] hit;

    always_comb begin
        for (int i = 0; i < `PM_NUM_BULLETS; i++) begin
            // zero-extend then subtract, keeps the sign of the offset
            dx[i]    = $signed({1'b0, draw_x}) - $signed({1'b0, regs.bullets[i][10:1]});
            dy[i]    = $signed({1'b0, draw_y}) - $signed({1'b0, regs.bullets[i][20:11]});
            sq_x[i]  = dx[i] * dx[i];
            sq_y[i]  = dy[i] * dy[i];
            dist2[i] = {1'b0, sq_x[i]} + {1'b0, sq_y[i]};
            hit[i]   = regs.bullets[i][0] && (dist2[i] <= radius_sq);  // valid only
        end
    end

    always_ff @(posedge pixel_clk) begin
        if (!rst_n) begin
            layer.bullet_on <= 1'b0;
        end else begin
            layer.bullet_on <= |hit;
        end
    end

endmodule

/* wall_hit.sv */
// square hit test of the current pixel against every valid wall block
`timescale 1ns/1ps
`include "pixel_mapper_defs.svh"

module wall_hit (
    input  logic                     pixel_clk,
    input  logic                     rst_n,
    input  pixel_mapper_pkg::coord_t draw_x,
    input  pixel_mapper_pkg::coord_t draw_y,
    regs_if.user                     regs,
    layer_if.wall_src                layer
);
    localparam logic [10:0] side = 11'(`PM_WALL_SIZE);

    logic [10:0] x0 [`PM_NUM_WALLS];
    logic [10:0] y0 [`PM_NUM_WALLS];
    logic [`PM_NUM_WALLS-1:0] in_x;
    logic [`PM_NUM_WALLS-1:0] in_y;
    logic [`PM_NUM_WALLS-1:0] hit;

    always_comb begin
        for (int i = 0; i < `PM_NUM_WALLS; i++) begin
            x0[i] = {1'b0, regs.walls[i][10:1]};  // top left corner
            y0[i] = {1'b0, regs.walls[i][20:11]};
            // extra bit so a wall near the edge does not wrap
            in_x[i] = ({1'b0, draw_x} >= x0[i]) && ({1'b0, draw_x} < x0[i] + side);
            in_y[i] = ({1'b0, draw_y} >= y0[i]) && ({1'b0, draw_y} < y0[i] + side);
            hit[i]  = regs.walls[i][0] && in_x[i] && in_y[i];
        end
    end

    always_ff @(posedge pixel_clk) begin
        if (!rst_n) begin
            layer.wall_on <= 1'b0;
        end else begin
            layer.wall_on <= |hit;
        end
    end

endmodule

/* text_layer.sv */
// text cell font bit pick and palette color lookup
`timescale 1ns/1ps

module text_layer (
    input  logic                        pixel_clk,
    input  logic                        rst_n,
    input  pixel_mapper_pkg::coord_t    draw_x,
    input  pixel_mapper_pkg::char_t     char_code,
    input  pixel_mapper_pkg::font_row_t font_row,
    regs_if.user                        regs,
    layer_if.text_src                   layer
);
    logic                        fg;
    logic [2:0]                  pal_idx;
    logic                        pal_half;
    pixel_mapper_pkg::reg_word_t pal_word;
    pixel_mapper_pkg::rgb444_t   c444;
    pixel_mapper_pkg::rgb888_t   c888;

    // leftmost pixel of the cell is font bit 7, bit 15 inverts the cell
    assign fg = font_row[3'd7 - draw_x[2:0]] ^ char_code[15];

    assign pal_idx  = fg ? char_code[7:5] : char_code[3:1];
    assign pal_half = fg ? char_code[4] : char_code[0];
    assign pal_word = regs.palette[pal_idx];
    assign c444     = pal_half ? pal_word[27:16] : pal_word[11:0];

    // 4 to 8 bits by repeating each nibble
    assign c888 = {c444[11:8], c444[11:8],
                   c444[7:4],  c444[7:4],
                   c444[3:0],  c444[3:0]};

    always_ff @(posedge pixel_clk) begin
        if (!rst_n) begin
            layer.text_on <= 1'b0;
        end else begin
            layer.text_on <= |char_code;  // code 0 means no text here
        end
    end

    always_ff @(posedge pixel_clk) begin
        layer.text_color <= c888;
    end

endmodule

/* layer_compositor.sv */
// priority select of the winning layer and registered RGB output
`timescale 1ns/1ps
`include "pixel_mapper_defs.svh"

module layer_compositor (
    input  logic        pixel_clk,
    input  logic        rst_n,
    input  logic        blank,
    output logic [7:0]  red,
    output logic [7:0]  green,
    output logic [7:0]  blue,
    regs_if.user        regs,
    layer_if.sink       layer
);
    logic                      blank_d;  // aligned with stage one results
    pixel_mapper_pkg::layer_t  sel;
    pixel_mapper_pkg::rgb888_t rgb_next;

    always_ff @(posedge pixel_clk) begin
        if (!rst_n) begin
            blank_d <= 1'b0;
        end else begin
            blank_d <= blank;
        end
    end

    always_comb begin
        if (!blank_d) sel = pixel_mapper_pkg::layer_blank;  // low is off screen
        else if (layer.text_on) sel = pixel_mapper_pkg::layer_text;
        else if (layer.bullet_on) sel = pixel_mapper_pkg::layer_bullet;
        else if (layer.wall_on) sel = pixel_mapper_pkg::layer_wall;
        else sel = pixel_mapper_pkg::layer_bg;
    end

    always_comb begin
        case (sel)
            pixel_mapper_pkg::layer_text:   rgb_next = layer.text_color;
            pixel_mapper_pkg::layer_bullet: rgb_next = `PM_BULLET_RGB;
            pixel_mapper_pkg::layer_wall:   rgb_next = regs.wall_color;
            pixel_mapper_pkg::layer_bg:     rgb_next = regs.bg_color;
            default:                        rgb_next = '0;
        endcase
    end

    always_ff @(posedge pixel_clk) begin
        if (!rst_n) begin
            red   <= 8'h00;
            green <= 8'h00;
            blue  <= 8'h00;
        end else begin
            red   <= rgb_next[23:16];
            green <= rgb_next[15:8];
            blue  <= rgb_next[7:0];
        end
    end

    // an off-screen pixel leaves the pipeline black two cycles later
    a_blank_black: assert property (
        @(posedge pixel_clk) disable iff (!rst_n)
        !blank |=> ##1 ((red == 8'h00) && (green == 8'h00) && (blue == 8'h00))
    );

endmodule

/* pixel_mapper_top.sv */
// layered pixel color mapper top with APB register port and two-stage pipeline
`timescale 1ns/1ps

module pixel_mapper_top (
    input  logic                        pixel_clk,
    input  logic                        rst_n,
    input  pixel_mapper_pkg::coord_t    draw_x,
    input  pixel_mapper_pkg::coord_t    draw_y,
    input  logic                        blank,
    input  pixel_mapper_pkg::char_t     char_code,
    input  pixel_mapper_pkg::font_row_t font_row,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  pixel_mapper_pkg::apb_addr_t paddr,
    input  pixel_mapper_pkg::reg_word_t pwdata,
    output pixel_mapper_pkg::reg_word_t prdata,
    output logic                        pready,
    output logic                        pslverr,
    output logic [7:0]                  red,
    output logic [7:0]                  green,
    output logic [7:0]                  blue
);
    regs_if  regs_bus ();
    layer_if layer_bus ();

    apb_regfile regfile_i (
        .pixel_clk (pixel_clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .regs      (regs_bus.owner)
    );

    // stage one, all three see the same pixel
    text_layer text_i (
        .pixel_clk (pixel_clk),
        .rst_n     (rst_n),
        .draw_x    (draw_x),
        .char_code (char_code),
        .font_row  (font_row),
        .regs      (regs_bus.user),
        .layer     (layer_bus.text_src)
    );

    bullet_hit bullet_i (
        .pixel_clk (pixel_clk),
        .rst_n     (rst_n),
        .draw_x    (draw_x),
        .draw_y    (draw_y),
        .regs      (regs_bus.user),
        .layer     (layer_bus.bullet_src)
    );

    wall_hit wall_i (
        .pixel_clk (pixel_clk),
        .rst_n     (rst_n),
        .draw_x    (draw_x),
        .draw_y    (draw_y),
        .regs      (regs_bus.user),
        .layer     (layer_bus.wall_src)
    );

    layer_compositor comp_i (
        .pixel_clk (pixel_clk),
        .rst_n     (rst_n),
        .blank     (blank),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .regs      (regs_bus.user),
        .layer     (layer_bus.sink)
    );

endmodule

/* tb_pixel_mapper.sv */
// directed testbench for the layered pixel color mapper with APB register port
`timescale 1ns/1ps
`include "pixel_mapper_defs.svh"

module tb_pixel_mapper;
    localparam int test_cycles = 300;  // about 280 cycles of tests
    localparam int margin_cycles = 200;

    logic pixel_clk;
    logic rst_n;
    pixel_mapper_pkg::coord_t    draw_x;
    pixel_mapper_pkg::coord_t    draw_y;
    logic                        blank;
    pixel_mapper_pkg::char_t     char_code;
    pixel_mapper_pkg::font_row_t font_row;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    pixel_mapper_pkg::apb_addr_t paddr;
    pixel_mapper_pkg::reg_word_t pwdata;
    pixel_mapper_pkg::reg_word_t prdata;
    logic                        pready;
    logic                        pslverr;
    logic [7:0]                  red;
    logic [7:0]                  green;
    logic [7:0]                  blue;

    // register contents as software last wrote them
    logic [31:0] pal_m [8];
    logic [31:0] bul_m [8];
    logic [31:0] wal_m [8];
    logic [23:0] bg_m;
    logic [23:0] wcol_m;

    logic [23:0] exp_q [$];
    int          due_q [$];
    logic [23:0] got_rgb;
    logic [23:0] want_rgb;
    int cyc = 0;
    int checks = 0;
    int errors = 0;
    int err_mark = 0;
    logic wr_err;

    pixel_mapper_top dut_i (.*);

    initial begin
        pixel_clk = 1'b0;
        forever #20 pixel_clk = ~pixel_clk;
    end

    always @(posedge pixel_clk) cyc <= cyc + 1;

    initial begin
        #((test_cycles + margin_cycles) * 40);
        $display("timeout: run did not finish within %0d cycles", test_cycles + margin_cycles);
        $display("Checks failed");
        $finish;
    end

    function automatic logic [31:0] pos_word(int x, int y, logic valid);
        return {11'b0, y[9:0], x[9:0], valid};
    endfunction

    // priority rules applied to the register copies
    function automatic logic [23:0] expect_rgb(int x, int y, logic vis, logic [15:0] code,
                                               logic [7:0] row);
        logic       fg;
        int         idx;
        logic       half;
        logic [11:0] c;
        int         dx;
        int         dy;
        int         bx;
        int         by;
        if (!vis) return 24'h0;
        if (code != 16'h0) begin
            fg = row[7 - (x % 8)] ^ code[15];
            idx = fg ? code[7:5] : code[3:1];
            half = fg ? code[4] : code[0];
            c = half ? pal_m[idx][27:16] : pal_m[idx][11:0];
            return {c[11:8], c[11:8], c[7:4], c[7:4], c[3:0], c[3:0]};
        end
        for (int i = 0; i < 8; i++) begin
            bx = bul_m[i][10:1];
            by = bul_m[i][20:11];
            dx = x - bx;
            dy = y - by;
            if (bul_m[i][0] && dx * dx + dy * dy <= `PM_BULLET_RADIUS * `PM_BULLET_RADIUS)
                return `PM_BULLET_RGB;
        end
        for (int i = 0; i < 8; i++) begin
            bx = wal_m[i][10:1];
            by = wal_m[i][20:11];
            if (wal_m[i][0] && x >= bx && x < bx + `PM_WALL_SIZE &&
                y >= by && y < by + `PM_WALL_SIZE)
                return wcol_m;
        end
        return bg_m;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        assert (got == want) else begin
            $display("Error at %0t ns: %s got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    // pixel results come out two cycles after they go in
    always @(negedge pixel_clk) begin
        if (due_q.size() > 0 && due_q[0] == cyc) begin
            got_rgb = {red, green, blue};
            want_rgb = exp_q.pop_front();
            void'(due_q.pop_front());
            checks++;
            assert (got_rgb == want_rgb) else begin
                $display("Error at %0t ns: {red,green,blue} got %h expected %h",
                         $time, got_rgb, want_rgb);
                errors++;
            end
        end
    end

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        @(negedge pixel_clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(negedge pixel_clk);
        penable = 1'b1;
        err = pslverr;
        @(negedge pixel_clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        if (addr < `PM_ADDR_BULLET) pal_m[addr[4:2]] = data;
        else if (addr < `PM_ADDR_WALL) bul_m[addr[4:2]] = data;
        else if (addr < `PM_ADDR_BG) wal_m[addr[4:2]] = data;
        else if (addr == `PM_ADDR_BG) bg_m = data[23:0];
        else if (addr == `PM_ADDR_WALLCOL) wcol_m = data[23:0];
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic [31:0] want, input logic want_err);
        @(negedge pixel_clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        @(negedge pixel_clk);
        penable = 1'b1;
        check_val("prdata", prdata, want);
        check_val("pslverr", pslverr, want_err);
        check_val("pready", pready, 1);
        @(negedge pixel_clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic drive_pixel(input int x, input int y, input logic vis,
                               input logic [15:0] code, input logic [7:0] row);
        @(negedge pixel_clk);
        draw_x = 10'(x);
        draw_y = 10'(y);
        blank = vis;
        char_code = code;
        font_row = row;
        exp_q.push_back(expect_rgb(x, y, vis, code, row));
        due_q.push_back(cyc + 2);
    endtask

    task automatic drain;
        while (due_q.size() > 0) @(negedge pixel_clk);
    endtask

    task automatic report_test(input string name);
        $display("%s: %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    task automatic reset_blank_test;
        check_val("{red,green,blue}", {red, green, blue}, 0);
        apb_write(`PM_ADDR_BG, 32'h00abcdef, wr_err);
        apb_write(`PM_ADDR_WALLCOL, 32'h00102030, wr_err);
        apb_write(`PM_ADDR_PALETTE, 32'h0fff0fff, wr_err);
        drive_pixel(10, 10, 1'b0, 16'h0010, 8'hff);  // would be white text if shown
        drive_pixel(11, 10, 1'b0, 16'h0000, 8'h00);
        drive_pixel(12, 10, 1'b1, 16'h0000, 8'h00);
        drain();
        report_test("reset and blank");
    endtask

    task automatic register_test;
        apb_write(`PM_ADDR_PALETTE + 12, 32'h0abc0def, wr_err);
        apb_read(`PM_ADDR_PALETTE + 12, 32'h0abc0def, 1'b0);
        apb_write(`PM_ADDR_BULLET + 20, 32'h00123456, wr_err);
        apb_read(`PM_ADDR_BULLET + 20, 32'h00123456, 1'b0);
        apb_write(`PM_ADDR_WALL + 28, 32'h00a55a5a, wr_err);
        apb_read(`PM_ADDR_WALL + 28, 32'h00a55a5a, 1'b0);
        apb_write(`PM_ADDR_BG, 32'hff123456, wr_err);
        apb_read(`PM_ADDR_BG, 32'h00123456, 1'b0);
        apb_write(`PM_ADDR_WALLCOL, 32'h00654321, wr_err);
        apb_read(`PM_ADDR_WALLCOL, 32'h00654321, 1'b0);
        apb_write(8'h80, 32'hffffffff, wr_err);
        check_val("pslverr", wr_err, 1);
        apb_read(8'h80, 32'h0, 1'b1);
        apb_read(8'h68, 32'h0, 1'b1);
        apb_read(`PM_ADDR_PALETTE, 32'h0fff0fff, 1'b0);  // unmapped write left it alone
        report_test("register access");
    endtask

    task automatic text_test;
        logic [15:0] codes [4];
        codes = '{16'h00a5, 16'h80a5, 16'h005a, 16'h805a};  // both halves, both inverts
        for (int i = 0; i < 8; i++)
            apb_write(`PM_ADDR_PALETTE + 4 * i, {4'h0, 12'($urandom), 4'h0, 12'($urandom)}, wr_err);
        for (int k = 0; k < 4; k++)
            for (int x = 64; x < 72; x++) drive_pixel(x, 20, 1'b1, codes[k], 8'b1100_1010);
        drive_pixel(75, 20, 1'b1, 16'h00c3, 8'h0f);
        drain();
        apb_write(`PM_ADDR_BULLET, pos_word(300, 200, 1'b1), wr_err);
        drive_pixel(300, 200, 1'b1, 16'h00a5, 8'hf0);
        drive_pixel(300, 200, 1'b1, 16'h0000, 8'hf0);
        drain();
        apb_write(`PM_ADDR_BULLET, 32'h0, wr_err);
        report_test("text");
    endtask

    task automatic bullet_test;
        int bx;
        int by;
        bx = $urandom_range(500, 16);
        by = $urandom_range(400, 16);
        apb_write(`PM_ADDR_BULLET + 8, pos_word(bx, by, 1'b1), wr_err);
        drive_pixel(bx, by, 1'b1, 16'h0, 8'h0);
        drive_pixel(bx + 4, by, 1'b1, 16'h0, 8'h0);
        drive_pixel(bx, by - 4, 1'b1, 16'h0, 8'h0);
        drive_pixel(bx + 5, by, 1'b1, 16'h0, 8'h0);
        drive_pixel(bx - 3, by + 3, 1'b1, 16'h0, 8'h0);
        drain();
        apb_write(`PM_ADDR_WALL + 4, pos_word(bx - 8, by - 8, 1'b1), wr_err);
        drive_pixel(bx, by, 1'b1, 16'h0, 8'h0);  // bullet over wall
        drive_pixel(bx + 5, by, 1'b1, 16'h0, 8'h0);
        drain();
        apb_write(`PM_ADDR_BULLET + 8, pos_word(bx, by, 1'b0), wr_err);
        drive_pixel(bx, by, 1'b1, 16'h0, 8'h0);
        drain();
        apb_write(`PM_ADDR_WALL + 4, 32'h0, wr_err);
        report_test("bullets");
    endtask

    task automatic wall_test;
        int wx;
        int wy;
        wx = $urandom_range(600, 40);
        wy = $urandom_range(440, 40);
        apb_write(`PM_ADDR_WALL + 16, pos_word(wx, wy, 1'b1), wr_err);
        drive_pixel(wx, wy, 1'b1, 16'h0, 8'h0);
        drive_pixel(wx + 31, wy, 1'b1, 16'h0, 8'h0);
        drive_pixel(wx, wy + 31, 1'b1, 16'h0, 8'h0);
        drive_pixel(wx + 31, wy + 31, 1'b1, 16'h0, 8'h0);
        drive_pixel(wx - 1, wy, 1'b1, 16'h0, 8'h0);
        drive_pixel(wx + 32, wy, 1'b1, 16'h0, 8'h0);
        drive_pixel(wx, wy - 1, 1'b1, 16'h0, 8'h0);
        drive_pixel(wx, wy + 32, 1'b1, 16'h0, 8'h0);
        drain();
        apb_write(`PM_ADDR_WALL + 16, 32'h0, wr_err);
        report_test("walls");
    endtask

    // one pixel per cycle through wall, bullet, text and blank spans
    task automatic streaming_test;
        logic [15:0] code;
        logic        vis;
        apb_write(`PM_ADDR_WALL, pos_word(200, 48, 1'b1), wr_err);
        apb_write(`PM_ADDR_BULLET + 12, pos_word(240, 60, 1'b1), wr_err);
        for (int x = 190; x < 270; x++) begin
            code = (x >= 250 && x < 258) ? 16'h00a5 : 16'h0;
            vis = !(x >= 264 && x < 267);
            drive_pixel(x, 60, vis, code, 8'h3c);
        end
        drain();
        report_test("streaming");
    endtask

    initial begin
        rst_n = 1'b0;
        draw_x = '0;
        draw_y = '0;
        blank = 1'b0;
        char_code = '0;
        font_row = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        bg_m = '0;
        wcol_m = '0;
        foreach (pal_m[i]) begin
            pal_m[i] = '0;
            bul_m[i] = '0;
            wal_m[i] = '0;
        end
        void'($urandom(32'h9195));
        repeat (2) @(negedge pixel_clk);
        rst_n = 1'b1;
        reset_blank_test();
        register_test();
        text_test();
        bullet_test();
        wall_test();
        streaming_test();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+.
pixel_mapper_pkg.sv
pixel_mapper_if.sv
apb_regfile.sv
bullet_hit.sv
wall_hit.sv
text_layer.sv
layer_compositor.sv
pixel_mapper_top.sv
tb_pixel_mapper.sv
